/* common/vertex_fetch_consts.svh */
`ifndef VERTEX_FETCH_CONSTS_SVH
`define VERTEX_FETCH_CONSTS_SVH

// byte address width of the vertex buffer master port
`define VF_ADDR_WIDTH 26

// one triangle record is three vertices of five attribute words
`define VF_WORDS_PER_TRI 15

// record FIFO holds 2**VF_FIFO_DEPTH_LOG2 triangles
`define VF_FIFO_DEPTH_LOG2 2

`endif

/* common/vertex_fetch_pkg.sv */
`include "vertex_fetch_consts.svh"

package vertex_fetch_pkg;

    // one 32-bit word as it comes off the memory port
    typedef logic [31:0] word_t;

    // index 0 holds the first word read for the triangle
    typedef word_t [`VF_WORDS_PER_TRI-1:0] triangle_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for fetch_enable or a free credit
        HEADER, // triangle count read in flight
        BURST   // issuing the reads of one triangle
    } fetch_state_t;

endpackage

/* common/fetch_count_if.sv */
interface fetch_count_if;

    vertex_fetch_pkg::word_t tri_total;   // triangle count from the header
    logic                    header_load; // header beat seen this cycle
    vertex_fetch_pkg::word_t header_word;
    logic                    tri_issued;  // sequencer starts a triangle
    logic                    tri_received; // assembler finished a record
    logic                    tri_delivered; // FIFO popped a record
    logic                    issue_ok;
    logic                    header_done;

    modport sequencer (
        input  issue_ok,
        input  header_done,
        input  header_load,
        output tri_issued
    );

    modport assembler (
        input  header_done,
        output header_load,
        output header_word,
        output tri_received
    );

    modport fifo (
        output tri_delivered
    );

    modport counters (
        input  header_load,
        input  header_word,
        input  tri_issued,
        input  tri_received,
        input  tri_delivered,
        output tri_total,
        output issue_ok,
        output header_done
    );

endinterface

/* fetch_control/fetch_sequencer.sv */
`include "vertex_fetch_consts.svh"

module fetch_sequencer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_enable,
    input  logic [`VF_ADDR_WIDTH-1:0] vertex_buffer_base,
    input  logic                      master_waitrequest,
    output logic [`VF_ADDR_WIDTH-1:0] master_address,
    output logic                      master_read,
    fetch_count_if.sequencer          cnt
);

    localparam int BEAT_W = $clog2(`VF_WORDS_PER_TRI);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`VF_WORDS_PER_TRI - 1);
    localparam logic [`VF_ADDR_WIDTH-1:0] WORD_BYTES = `VF_ADDR_WIDTH'(4);

    vertex_fetch_pkg::fetch_state_t state;
    logic [`VF_ADDR_WIDTH-1:0]      fetch_addr;
    logic [BEAT_W-1:0]              beat;
    logic                           accepted;

    assign accepted       = master_read && !master_waitrequest;
    assign master_address = fetch_addr; // only moves on an accepted read
    assign cnt.tri_issued = (state == vertex_fetch_pkg::IDLE) && cnt.issue_ok;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state       <= vertex_fetch_pkg::IDLE;
            master_read <= 1'b0;
            fetch_addr  <= '0;
            beat        <= '0;
        end else begin
            case (state)
                vertex_fetch_pkg::IDLE: begin
                    if (cnt.issue_ok) begin
                        master_read <= 1'b1; // fetch_addr already points at the next word
                        beat        <= '0;
                        state       <= vertex_fetch_pkg::BURST;
                    end else if (fetch_enable && !cnt.header_done) begin
                        fetch_addr  <= vertex_buffer_base;
                        master_read <= 1'b1;
                        state       <= vertex_fetch_pkg::HEADER;
                    end
                end
                vertex_fetch_pkg::HEADER: begin
                    if (accepted) begin
                        master_read <= 1'b0;
                        fetch_addr  <= fetch_addr + WORD_BYTES;
                    end
                    // wait for the count so a second fetch_enable cannot race it
                    if (cnt.header_load) begin
                        state <= vertex_fetch_pkg::IDLE;
                    end
                end
                vertex_fetch_pkg::BURST: begin
                    if (accepted) begin
                        fetch_addr <= fetch_addr + WORD_BYTES;
                        if (beat == LAST_BEAT) begin
                            master_read <= 1'b0;
                            state       <= vertex_fetch_pkg::IDLE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: begin
                    master_read <= 1'b0;
                    state       <= vertex_fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // a stalled request keeps its read and its address until the slave takes it
    assert property (@(posedge clock) disable iff (!reset)
        master_read && master_waitrequest |=> master_read && $stable(master_address));

endmodule

/* fetch_control/fetch_counters.sv */
`include "vertex_fetch_consts.svh"

module fetch_counters #(
    parameter int DEPTH_LOG2 = `VF_FIFO_DEPTH_LOG2
) (
    input  logic            clock,
    input  logic            reset,
    output logic            done_out,
    fetch_count_if.counters cnt
);

    localparam vertex_fetch_pkg::word_t DEPTH = 32'(2 ** DEPTH_LOG2);

    vertex_fetch_pkg::word_t issued;
    vertex_fetch_pkg::word_t received;
    vertex_fetch_pkg::word_t delivered;
    vertex_fetch_pkg::word_t in_flight;

    // triangles holding a FIFO slot, either queued or still being read
    assign in_flight = issued - delivered;

    assign cnt.issue_ok = (issued < cnt.tri_total) && (in_flight < DEPTH);
    assign done_out     = (cnt.tri_total != '0) && (delivered == cnt.tri_total);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cnt.tri_total   <= '0;
            cnt.header_done <= 1'b0;
            issued          <= '0;
            received        <= '0;
            delivered       <= '0;
        end else begin
            if (cnt.header_load) begin
                cnt.tri_total   <= cnt.header_word;
                cnt.header_done <= (cnt.header_word != '0); // a zero count waits for a new enable
            end
            if (cnt.tri_issued) begin
                issued <= issued + 1'b1;
            end
            if (cnt.tri_received) begin
                received <= received + 1'b1;
            end
            if (cnt.tri_delivered) begin
                delivered <= delivered + 1'b1;
            end
        end
    end

    // records flow sequencer to assembler to FIFO, never ahead of the stage before
    assert property (@(posedge clock) disable iff (!reset)
        (delivered <= received) && (received <= issued));

endmodule

/* src/vertex_assembler.sv */
`include "vertex_fetch_consts.svh"

module vertex_assembler (
    input  logic                          clock,
    input  logic                          reset,
    input  vertex_fetch_pkg::word_t       master_readdata,
    input  logic                          master_readdatavalid,
    output logic                          push,
    output vertex_fetch_pkg::triangle_t   record,
    fetch_count_if.assembler              cnt
);

    localparam int BEAT_W = $clog2(`VF_WORDS_PER_TRI);
    localparam logic [BEAT_W-1:0] LAST_SLOT = BEAT_W'(`VF_WORDS_PER_TRI - 1);

    logic [BEAT_W-1:0] slot;
    logic              beat_valid;

    // the first beat after a fetch_enable is always the triangle count
    assign cnt.header_load  = master_readdatavalid && !cnt.header_done;
    assign cnt.header_word  = master_readdata;
    assign beat_valid       = master_readdatavalid && cnt.header_done;
    assign cnt.tri_received = push;

    always_ff @(posedge clock) begin
        if (beat_valid) begin
            record[slot] <= master_readdata;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            slot <= '0;
            push <= 1'b0;
        end else begin
            push <= beat_valid && (slot == LAST_SLOT); // record is complete one edge later
            if (beat_valid) begin
                if (slot == LAST_SLOT) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

/* src/triangle_fifo.sv */
`include "vertex_fetch_consts.svh"

module triangle_fifo #(
    parameter int DEPTH_LOG2 = `VF_FIFO_DEPTH_LOG2
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        push,
    input  vertex_fetch_pkg::triangle_t record,
    input  logic                        stall_in,
    output logic                        output_valid,
    output vertex_fetch_pkg::triangle_t vertex_out,
    fetch_count_if.fifo                 cnt
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    vertex_fetch_pkg::triangle_t mem [DEPTH];
    logic [DEPTH_LOG2-1:0]       wr_ptr;
    logic [DEPTH_LOG2-1:0]       rd_ptr;
    logic [DEPTH_LOG2:0]         count;
    logic                        pop;

    // show-ahead, the head record is on vertex_out whenever the FIFO holds one
    assign pop               = (count != '0) && !stall_in;
    assign output_valid      = pop;
    assign vertex_out        = mem[rd_ptr];
    assign cnt.tri_delivered = pop;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= record;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the credit limit in fetch_counters must keep the assembler from overfilling us
    assert property (@(posedge clock) disable iff (!reset)
        push |-> (count != (DEPTH_LOG2 + 1)'(DEPTH)));

endmodule

/* src/rasterizer_vertex_fetch.sv */
`include "vertex_fetch_consts.svh"

module rasterizer_vertex_fetch (
    input  logic                        clock,
    input  logic                        reset,

    output logic [`VF_ADDR_WIDTH-1:0]   master_address,
    output logic                        master_read,
    input  vertex_fetch_pkg::word_t     master_readdata,
    input  logic                        master_readdatavalid,
    input  logic                        master_waitrequest,

    input  logic                        fetch_enable,
    input  logic [`VF_ADDR_WIDTH-1:0]   vertex_buffer_base,

    input  logic                        stall_in,
    output logic                        output_valid,
    output vertex_fetch_pkg::triangle_t vertex_out,
    output logic                        done_out
);

    logic                        push;
    vertex_fetch_pkg::triangle_t record;

    fetch_count_if cnt ();

    fetch_sequencer i_fetch_sequencer (
        .clock              (clock),
        .reset              (reset),
        .fetch_enable       (fetch_enable),
        .vertex_buffer_base (vertex_buffer_base),
        .master_waitrequest (master_waitrequest),
        .master_address     (master_address),
        .master_read        (master_read),
        .cnt                (cnt.sequencer)
    );

    fetch_counters #(.DEPTH_LOG2(`VF_FIFO_DEPTH_LOG2)) i_fetch_counters (
        .clock    (clock),
        .reset    (reset),
        .done_out (done_out),
        .cnt      (cnt.counters)
    );

    vertex_assembler i_vertex_assembler (
        .clock                (clock),
        .reset                (reset),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .push                 (push),
        .record               (record),
        .cnt                  (cnt.assembler)
    );

    triangle_fifo #(.DEPTH_LOG2(`VF_FIFO_DEPTH_LOG2)) i_triangle_fifo (
        .clock        (clock),
        .reset        (reset),
        .push         (push),
        .record       (record),
        .stall_in     (stall_in),
        .output_valid (output_valid),
        .vertex_out   (vertex_out),
        .cnt          (cnt.fifo)
    );

endmodule

/* sim/avalon_read_memory.sv */
`include "vertex_fetch_consts.svh"

module avalon_read_memory #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`VF_ADDR_WIDTH-1:0] address,
    input  logic                      read,
    input  logic                      wait_next,    // waitrequest for the coming edge
    input  logic [2:0]                latency_next, // latency given to a read taken at that edge
    output logic                      waitrequest,
    output logic [31:0]               readdata,
    output logic                      readdatavalid,
    output int                        accept_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] data_q [$];
    int          due_q [$];
    int          cycle;
    int          last_due;

    initial begin
        waitrequest   = 1'b1;
        readdata      = '0;
        readdatavalid = 1'b0;
        accept_count  = 0;
    end

    // outputs change on the falling edge so the DUT sees them settled at the rising edge
    always @(negedge clock or negedge reset) begin
        int due;
        if (!reset) begin
            data_q.delete();
            due_q.delete();
            cycle         = 0;
            last_due      = 0;
            waitrequest   <= 1'b1;
            readdatavalid <= 1'b0;
            readdata      <= '0;
            accept_count  <= 0;
        end else begin
            cycle++;
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                readdatavalid <= 1'b1;
                readdata      <= data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                readdatavalid <= 1'b0;
            end
            waitrequest <= wait_next;
            if (read && !wait_next) begin
                due = cycle + int'(latency_next);
                if (due <= last_due) begin
                    due = last_due + 1; // responses stay in request order
                end
                last_due = due;
                due_q.push_back(due);
                data_q.push_back(mem[address[IDX_W+1:2]]);
                accept_count <= accept_count + 1;
            end
        end
    end

endmodule

/* sim/tb_rasterizer_vertex_fetch.sv */
`include "vertex_fetch_consts.svh"

module tb_rasterizer_vertex_fetch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUNS                  = 3;
    localparam int MAX_COUNT             = 10;
    localparam int WORDS                 = `VF_WORDS_PER_TRI;
    localparam int CREDITS               = 2 ** `VF_FIFO_DEPTH_LOG2;
    localparam int CLOCK_NS              = 4;
    localparam int RESET_CYCLES          = 8;
    localparam int STALL_CYCLES          = 160;
    localparam int WORST_CYCLES_PER_WORD = 8;
    localparam int MEM_WORDS             = 1024;
    localparam int WATCHDOG_NS           =
        RUNS * (1 + WORDS * MAX_COUNT) * WORST_CYCLES_PER_WORD * CLOCK_NS * 2;

    logic                        clock = 1'b0;
    logic                        reset;
    logic [`VF_ADDR_WIDTH-1:0]   master_address;
    logic                        master_read;
    vertex_fetch_pkg::word_t     master_readdata;
    logic                        master_readdatavalid;
    logic                        master_waitrequest;
    logic                        fetch_enable;
    logic [`VF_ADDR_WIDTH-1:0]   vertex_buffer_base;
    logic                        stall_in;
    logic                        output_valid;
    vertex_fetch_pkg::triangle_t vertex_out;
    logic                        done_out;

    logic                        mem_wait;
    logic [2:0]                  mem_latency;
    int                          mem_accepts;

    logic [31:0]                 lfsr_state = 32'hed68;
    logic                        checking;
    logic                        done_seen;
    logic [`VF_ADDR_WIDTH-1:0]   run_base;
    int                          run_index;
    int                          run_count;
    int                          base_word;
    int                          outputs_seen;
    int                          reads_seen;
    int                          run_errors;

    always #(CLOCK_NS / 2) clock = ~clock;

    rasterizer_vertex_fetch i_rasterizer_vertex_fetch (
        .clock                (clock),
        .reset                (reset),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_waitrequest   (master_waitrequest),
        .fetch_enable         (fetch_enable),
        .vertex_buffer_base   (vertex_buffer_base),
        .stall_in             (stall_in),
        .output_valid         (output_valid),
        .vertex_out           (vertex_out),
        .done_out             (done_out)
    );

    avalon_read_memory #(.MEM_WORDS(MEM_WORDS)) i_memory (
        .clock         (clock),
        .reset         (reset),
        .address       (master_address),
        .read          (master_read),
        .wait_next     (mem_wait),
        .latency_next  (mem_latency),
        .waitrequest   (master_waitrequest),
        .readdata      (master_readdata),
        .readdatavalid (master_readdatavalid),
        .accept_count  (mem_accepts)
    );

    // galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    task automatic next_cycle();
        @(negedge clock);
        stall_in = (take_bits(2) == 32'd0); // rasterizer stalls about one cycle in four
    endtask

    // the reference model sees the DUT outputs as they stood just before this edge
    always @(posedge clock) begin
        vertex_fetch_pkg::word_t expected;
        int started;
        if (checking && reset) begin
            if (master_read && !master_waitrequest) begin
                if (reads_seen >= 1 + WORDS * run_count) begin
                    $display("run %0d: a read was accepted past the end of the buffer", run_index);
                    run_errors++;
                end else if (master_address != run_base + `VF_ADDR_WIDTH'(4 * reads_seen)) begin
                    $display("Fail run%0d read%0d address: expected %h actual %h", run_index,
                             reads_seen, run_base + `VF_ADDR_WIDTH'(4 * reads_seen),
                             master_address);
                    run_errors++;
                end
                reads_seen++;
            end
            started = (mem_accepts + WORDS - 2) / WORDS; // the header read starts no triangle
            if (started - outputs_seen > CREDITS) begin
                $display("run %0d: %0d triangles started with only %0d delivered", run_index,
                         started, outputs_seen);
                run_errors++;
            end
            if (done_out && outputs_seen != run_count) begin
                $display("run %0d: done_out is high after %0d of %0d triangles", run_index,
                         outputs_seen, run_count);
                run_errors++;
            end
            if (done_seen && !done_out) begin
                $display("run %0d: done_out fell after it had risen", run_index);
                run_errors++;
            end
            done_seen = done_seen || done_out;
            if (output_valid) begin
                if (stall_in) begin
                    $display("run %0d: output_valid is high while stall_in is high", run_index);
                    run_errors++;
                end
                if (outputs_seen >= run_count) begin
                    $display("run %0d: a record was delivered after the last one", run_index);
                    run_errors++;
                end else begin
                    for (int w = 0; w < WORDS; w++) begin
                        expected = i_memory.mem[base_word + 1 + WORDS * outputs_seen + w];
                        if (vertex_out[w] != expected) begin
                            $display("Fail run%0d tri%0d word%0d: expected %h actual %h",
                                     run_index, outputs_seen, w, expected, vertex_out[w]);
                            run_errors++;
                        end
                    end
                end
                outputs_seen++;
            end
        end
        mem_wait    = (take_bits(2) == 32'd0);
        mem_latency = 3'(take_bits(3) % 6 + 1);
    end

    initial begin
        int passed;
        int failed;
        reset              = 1'b0;
        fetch_enable       = 1'b0;
        stall_in           = 1'b0;
        vertex_buffer_base = '0;
        checking           = 1'b0;
        done_seen          = 1'b0;
        mem_wait           = 1'b0;
        mem_latency        = 3'd1;
        passed             = 0;
        failed             = 0;
        for (int run = 0; run < RUNS; run++) begin
            run_index = run;
            checking  = 1'b0;
            reset     = 1'b0;
            repeat (RESET_CYCLES) next_cycle();
            for (int w = 0; w < MEM_WORDS; w++) begin
                i_memory.mem[w] = take_bits(32);
            end
            base_word                = int'(take_bits(9));
            run_count                = int'(take_bits(4) % 10) + 1;
            i_memory.mem[base_word]  = 32'(run_count); // header word holds the triangle count
            run_base                 = `VF_ADDR_WIDTH'(base_word * 4);
            vertex_buffer_base       = run_base;
            outputs_seen             = 0;
            reads_seen               = 0;
            run_errors               = 0;
            done_seen                = 1'b0;
            reset                    = 1'b1;
            checking                 = 1'b1;
            next_cycle();
            fetch_enable = 1'b1;
            next_cycle();
            fetch_enable = 1'b0;
            stall_in     = 1'b1; // held off long enough for the credit limit to fill the FIFO
            repeat (STALL_CYCLES) @(negedge clock);
            while (!done_out) begin
                next_cycle();
            end
            // a second enable after completion must not start another fetch
            repeat (4) next_cycle();
            fetch_enable = 1'b1;
            next_cycle();
            fetch_enable = 1'b0;
            repeat (20) next_cycle();
            if (mem_accepts != 1 + WORDS * run_count) begin
                $display("Fail run%0d read count: expected %0d actual %0d", run, 
                         1 + WORDS * run_count, mem_accepts);
                run_errors++;
            end
            if (outputs_seen != run_count) begin
                $display("Fail run%0d record count: expected %0d actual %0d", run, run_count,
                         outputs_seen);
                run_errors++;
            end
            checking = 1'b0;
            $display("run %0d: base %h, %0d triangles, %0d reads, %0d errors", run, run_base,
                     run_count, reads_seen, run_errors);
            if (run_errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("runs %0d, passed %0d, failed %0d", RUNS, passed, failed);
        if (failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the runs did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* rasterizer_vertex_fetch.f */
+incdir+common
common/vertex_fetch_pkg.sv
common/fetch_count_if.sv
fetch_control/fetch_sequencer.sv
fetch_control/fetch_counters.sv
src/vertex_assembler.sv
src/triangle_fifo.sv
src/rasterizer_vertex_fetch.sv
sim/avalon_read_memory.sv
sim/tb_rasterizer_vertex_fetch.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the vertex fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rasterizer_vertex_fetch \
    -f rasterizer_vertex_fetch.f \
    --Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
